// ==== include/rs_consts.svh ====
// Issue stage constants
`ifndef RS_CONSTS_SVH
`define RS_CONSTS_SVH

// Entries per reservation-station bank
`define RS_BANK_ENTRIES 4

// Physical register tag width
`define PREG_TAG_W 6

// ROB index width, giving a 16-entry ROB
`define ROB_IDX_W 4

// Tag broadcasts per cycle on the writeback bus
`define WB_PORTS 2

// Opaque operation word (opcode, immediate and friends)
`define OP_PAYLOAD_W 24

`endif

// ==== source/rs_pkg.sv ====
// Issue stage types
`include "rs_consts.svh"

package rs_pkg;

  // Physical register tag
  typedef logic [`PREG_TAG_W-1:0] preg_tag_t;

  // ROB index with the wrap bit on top
  typedef logic [`ROB_IDX_W:0] rob_age_t;

  // Operation word passed through to the FU
  typedef logic [`OP_PAYLOAD_W-1:0] op_payload_t;

  // Free entries in one bank, 0 up to full
  typedef logic [$clog2(`RS_BANK_ENTRIES + 1)-1:0] rs_cnt_t;

  // ======================================================================
  // Age compare
  // ======================================================================
  // True when age_a was allocated in the ROB before age_b
  function automatic logic age_is_older(input rob_age_t age_a, input rob_age_t age_b);
    logic                  wrap_a;
    logic                  wrap_b;
    logic [`ROB_IDX_W-1:0] idx_a;
    logic [`ROB_IDX_W-1:0] idx_b;
    wrap_a = age_a[`ROB_IDX_W];
    wrap_b = age_b[`ROB_IDX_W];
    idx_a  = age_a[`ROB_IDX_W-1:0];
    idx_b  = age_b[`ROB_IDX_W-1:0];
    if (wrap_a == wrap_b) begin
      return idx_a < idx_b;
    end
    // One side has wrapped, so the larger index is the older one
    return idx_a > idx_b;
  endfunction

endpackage

// ==== source/dispatch_steer.sv ====
// Dispatch bank steering
module dispatch_steer (
  input  logic            disp_valid_i,
  input  rs_pkg::rs_cnt_t free_cnt0_i,
  input  rs_pkg::rs_cnt_t free_cnt1_i,
  output logic            disp_ready_o,
  output logic [1:0]      alloc_o
);

  logic room0;
  logic room1;
  logic pick_bank1;

  // Room left in each bank
  assign room0 = (free_cnt0_i != '0);
  assign room1 = (free_cnt1_i != '0);

  // Emptier bank wins, bank 0 on a tie
  assign pick_bank1 = (free_cnt1_i > free_cnt0_i);

  // Accept while either bank can take one more
  assign disp_ready_o = room0 | room1;

  // ======================================================================
  // Allocate strobes
  // ======================================================================
  // The picked bank always has room when any bank does,
  // since a tie at zero means both are full
  assign alloc_o[0] = disp_valid_i & ~pick_bank1 & room0;
  assign alloc_o[1] = disp_valid_i & pick_bank1 & room1;

  // Every accepted operation lands in exactly one bank, otherwise none
  a_alloc_onehot: assert final ($onehot0(alloc_o) &&
                                ((|alloc_o) == (disp_valid_i & disp_ready_o)))
    else $error("dispatch_steer: transfer not steered to exactly one bank");

endmodule

// ==== source/rs_bank.sv ====
// Reservation-station bank
`include "rs_consts.svh"

module rs_bank (
  input  logic                                 clk,
  input  logic                                 rst_n,
  input  logic                                 flush_i,
  input  logic                                 alloc_i,
  input  rs_pkg::rob_age_t                     disp_age_i,
  input  rs_pkg::op_payload_t                  disp_payload_i,
  input  logic                                 disp_src0_valid_i,
  input  rs_pkg::preg_tag_t                    disp_src0_i,
  input  logic                                 disp_src0_ready_i,
  input  logic                                 disp_src1_valid_i,
  input  rs_pkg::preg_tag_t                    disp_src1_i,
  input  logic                                 disp_src1_ready_i,
  input  rs_pkg::preg_tag_t                    disp_dest_i,
  input  logic [`WB_PORTS-1:0]                 wb_valid_i,
  input  rs_pkg::preg_tag_t [`WB_PORTS-1:0]    wb_tag_i,
  output rs_pkg::rs_cnt_t                      free_cnt_o,
  output logic                                 cand_valid_o,
  output rs_pkg::rob_age_t                     cand_age_o,
  output rs_pkg::op_payload_t                  cand_payload_o,
  output rs_pkg::preg_tag_t                    cand_dest_o,
  input  logic                                 grant_i
);

  import rs_pkg::*;

  localparam int NUM_ENT = `RS_BANK_ENTRIES;
  localparam int IDX_W   = (NUM_ENT > 1) ? $clog2(NUM_ENT) : 1;

  // ======================================================================
  // Entry storage
  // ======================================================================
  logic [NUM_ENT-1:0] ent_valid_q;
  logic [NUM_ENT-1:0] src0_rdy_q;
  logic [NUM_ENT-1:0] src1_rdy_q;
  logic [NUM_ENT-1:0] src0_valid_q;
  logic [NUM_ENT-1:0] src1_valid_q;
  preg_tag_t          src0_tag_q    [NUM_ENT];
  preg_tag_t          src1_tag_q    [NUM_ENT];
  rob_age_t           ent_age_q     [NUM_ENT];
  op_payload_t        ent_payload_q [NUM_ENT];
  preg_tag_t          ent_dest_q    [NUM_ENT];

  logic [IDX_W-1:0]   alloc_idx;
  logic [NUM_ENT-1:0] ent_ready;
  logic               sel_found;
  logic [IDX_W-1:0]   sel_idx;
  rob_age_t           sel_age;

  // Any writeback port carrying this tag
  function automatic logic wb_hit(input preg_tag_t tag);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < `WB_PORTS; p++) begin
      hit = hit | (wb_valid_i[p] && (wb_tag_i[p] == tag));
    end
    return hit;
  endfunction

  // Lowest free slot and free count
  always_comb begin
    alloc_idx  = '0;
    free_cnt_o = '0;
    for (int i = NUM_ENT - 1; i >= 0; i--) begin
      if (!ent_valid_q[i]) begin
        alloc_idx  = IDX_W'(i);
        free_cnt_o = free_cnt_o + 1'b1;
      end
    end
  end

  // ======================================================================
  // Oldest-ready select
  // ======================================================================
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    sel_age   = '0;
    for (int i = 0; i < NUM_ENT; i++) begin
      // Unused sources count as ready
      ent_ready[i] = ent_valid_q[i] &
                     (~src0_valid_q[i] | src0_rdy_q[i]) &
                     (~src1_valid_q[i] | src1_rdy_q[i]);
      if (ent_ready[i] && (!sel_found || age_is_older(ent_age_q[i], sel_age))) begin
        sel_found = 1'b1;
        sel_idx   = IDX_W'(i);
        sel_age   = ent_age_q[i];
      end
    end
  end

  assign cand_valid_o   = sel_found;
  assign cand_age_o     = sel_age;
  assign cand_payload_o = ent_payload_q[sel_idx];
  assign cand_dest_o    = ent_dest_q[sel_idx];

  // Valid and ready bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid_q <= '0;
      src0_rdy_q  <= '0;
      src1_rdy_q  <= '0;
    end else if (flush_i) begin
      ent_valid_q <= '0;
    end else begin
      for (int i = 0; i < NUM_ENT; i++) begin
        if (ent_valid_q[i] && wb_hit(src0_tag_q[i])) begin
          src0_rdy_q[i] <= 1'b1;
        end
        if (ent_valid_q[i] && wb_hit(src1_tag_q[i])) begin
          src1_rdy_q[i] <= 1'b1;
        end
      end
      // Released slot and new slot never coincide
      if (grant_i) begin
        ent_valid_q[sel_idx] <= 1'b0;
      end
      if (alloc_i) begin
        ent_valid_q[alloc_idx] <= 1'b1;
        // Same-cycle broadcast is seen by the new entry
        src0_rdy_q[alloc_idx]  <= disp_src0_ready_i | wb_hit(disp_src0_i);
        src1_rdy_q[alloc_idx]  <= disp_src1_ready_i | wb_hit(disp_src1_i);
      end
    end
  end

  // Entry fields
  always_ff @(posedge clk) begin
    if (alloc_i) begin
      ent_age_q[alloc_idx]     <= disp_age_i;
      ent_payload_q[alloc_idx] <= disp_payload_i;
      ent_dest_q[alloc_idx]    <= disp_dest_i;
      src0_valid_q[alloc_idx]  <= disp_src0_valid_i;
      src0_tag_q[alloc_idx]    <= disp_src0_i;
      src1_valid_q[alloc_idx]  <= disp_src1_valid_i;
      src1_tag_q[alloc_idx]    <= disp_src1_i;
    end
  end

  // Steering must not pick a full bank
  a_no_alloc_full: assert property (@(posedge clk) disable iff (!rst_n)
    alloc_i |-> (free_cnt_o != '0))
    else $error("rs_bank: allocation into a full bank");

  // Arbiter grants only a presented candidate
  a_grant_cand: assert property (@(posedge clk) disable iff (!rst_n)
    grant_i |-> cand_valid_o)
    else $error("rs_bank: grant without candidate");

endmodule

// ==== source/issue_arbiter.sv ====
// Issue arbiter
module issue_arbiter (
  input  logic                cand_valid0_i,
  input  rs_pkg::rob_age_t    cand_age0_i,
  input  rs_pkg::op_payload_t cand_payload0_i,
  input  rs_pkg::preg_tag_t   cand_dest0_i,
  input  logic                cand_valid1_i,
  input  rs_pkg::rob_age_t    cand_age1_i,
  input  rs_pkg::op_payload_t cand_payload1_i,
  input  rs_pkg::preg_tag_t   cand_dest1_i,
  input  logic                fu_ready_i,
  output logic                grant0_o,
  output logic                grant1_o,
  output logic                issue_valid_o,
  output rs_pkg::rob_age_t    issue_age_o,
  output rs_pkg::op_payload_t issue_payload_o,
  output rs_pkg::preg_tag_t   issue_dest_o
);

  import rs_pkg::*;

  logic pick1;

  // ======================================================================
  // Global oldest pick
  // ======================================================================
  // Bank 1 only when it is alone or strictly older
  assign pick1 = cand_valid1_i &
                 (~cand_valid0_i | age_is_older(cand_age1_i, cand_age0_i));

  assign issue_valid_o   = cand_valid0_i | cand_valid1_i;
  assign issue_age_o     = pick1 ? cand_age1_i : cand_age0_i;
  assign issue_payload_o = pick1 ? cand_payload1_i : cand_payload0_i;
  assign issue_dest_o    = pick1 ? cand_dest1_i : cand_dest0_i;

  // Release the entry only when the FU takes it
  assign grant0_o = cand_valid0_i & ~pick1 & fu_ready_i;
  assign grant1_o = pick1 & fu_ready_i;

  // Each FU handshake releases exactly one bank entry
  a_grant_excl: assert final (!(grant0_o && grant1_o) &&
                              ((grant0_o | grant1_o) == (issue_valid_o & fu_ready_i)))
    else $error("issue_arbiter: grants do not match the FU handshake");

endmodule

// ==== source/issue_stage.sv ====
// Integer issue stage
`include "rs_consts.svh"

module issue_stage (
  input  logic                              clk,
  input  logic                              rst_n,
  input  logic                              flush_i,
  input  logic                              disp_valid_i,
  input  rs_pkg::rob_age_t                  disp_age_i,
  input  rs_pkg::op_payload_t               disp_payload_i,
  input  logic                              disp_src0_valid_i,
  input  rs_pkg::preg_tag_t                 disp_src0_i,
  input  logic                              disp_src0_ready_i,
  input  logic                              disp_src1_valid_i,
  input  rs_pkg::preg_tag_t                 disp_src1_i,
  input  logic                              disp_src1_ready_i,
  input  rs_pkg::preg_tag_t                 disp_dest_i,
  output logic                              disp_ready_o,
  input  logic [`WB_PORTS-1:0]              wb_valid_i,
  input  rs_pkg::preg_tag_t [`WB_PORTS-1:0] wb_tag_i,
  output logic                              issue_valid_o,
  output rs_pkg::rob_age_t                  issue_age_o,
  output rs_pkg::op_payload_t               issue_payload_o,
  output rs_pkg::preg_tag_t                 issue_dest_o,
  input  logic                              fu_ready_i
);

  import rs_pkg::*;

  logic [1:0]  alloc;
  rs_cnt_t     free_cnt0;
  rs_cnt_t     free_cnt1;
  logic        cand_valid0;
  logic        cand_valid1;
  rob_age_t    cand_age0;
  rob_age_t    cand_age1;
  op_payload_t cand_payload0;
  op_payload_t cand_payload1;
  preg_tag_t   cand_dest0;
  preg_tag_t   cand_dest1;
  logic        grant0;
  logic        grant1;

  // ======================================================================
  // Steering
  // ======================================================================
  dispatch_steer u_steer (
    .disp_valid_i (disp_valid_i),
    .free_cnt0_i  (free_cnt0),
    .free_cnt1_i  (free_cnt1),
    .disp_ready_o (disp_ready_o),
    .alloc_o      (alloc)
  );

  // ======================================================================
  // Banks
  // ======================================================================
  rs_bank u_bank0 (
    .clk (clk), .rst_n (rst_n), .flush_i (flush_i),
    .alloc_i (alloc[0]),
    .disp_age_i (disp_age_i), .disp_payload_i (disp_payload_i),
    .disp_src0_valid_i (disp_src0_valid_i), .disp_src0_i (disp_src0_i),
    .disp_src0_ready_i (disp_src0_ready_i),
    .disp_src1_valid_i (disp_src1_valid_i), .disp_src1_i (disp_src1_i),
    .disp_src1_ready_i (disp_src1_ready_i), .disp_dest_i (disp_dest_i),
    .wb_valid_i (wb_valid_i), .wb_tag_i (wb_tag_i),
    .free_cnt_o (free_cnt0),
    .cand_valid_o (cand_valid0), .cand_age_o (cand_age0),
    .cand_payload_o (cand_payload0), .cand_dest_o (cand_dest0),
    .grant_i (grant0)
  );

  rs_bank u_bank1 (
    .clk (clk), .rst_n (rst_n), .flush_i (flush_i),
    .alloc_i (alloc[1]),
    .disp_age_i (disp_age_i), .disp_payload_i (disp_payload_i),
    .disp_src0_valid_i (disp_src0_valid_i), .disp_src0_i (disp_src0_i),
    .disp_src0_ready_i (disp_src0_ready_i),
    .disp_src1_valid_i (disp_src1_valid_i), .disp_src1_i (disp_src1_i),
    .disp_src1_ready_i (disp_src1_ready_i), .disp_dest_i (disp_dest_i),
    .wb_valid_i (wb_valid_i), .wb_tag_i (wb_tag_i),
    .free_cnt_o (free_cnt1),
    .cand_valid_o (cand_valid1), .cand_age_o (cand_age1),
    .cand_payload_o (cand_payload1), .cand_dest_o (cand_dest1),
    .grant_i (grant1)
  );

  // Single FU port
  issue_arbiter u_arb (
    .cand_valid0_i   (cand_valid0),
    .cand_age0_i     (cand_age0),
    .cand_payload0_i (cand_payload0),
    .cand_dest0_i    (cand_dest0),
    .cand_valid1_i   (cand_valid1),
    .cand_age1_i     (cand_age1),
    .cand_payload1_i (cand_payload1),
    .cand_dest1_i    (cand_dest1),
    .fu_ready_i      (fu_ready_i),
    .grant0_o        (grant0),
    .grant1_o        (grant1),
    .issue_valid_o   (issue_valid_o),
    .issue_age_o     (issue_age_o),
    .issue_payload_o (issue_payload_o),
    .issue_dest_o    (issue_dest_o)
  );

endmodule

// ==== tests/tb_issue_stage.sv ====
// Issue stage testbench
`include "rs_consts.svh"

module tb_issue_stage;
  timeunit 1ns;
  timeprecision 1ps;

  import rs_pkg::*;

  localparam int CAP = 2 * `RS_BANK_ENTRIES;

  // One outstanding operation as the model sees it
  typedef struct {
    int          seq;
    rob_age_t    age;
    op_payload_t payload;
    preg_tag_t   dest;
    logic        s0v;
    preg_tag_t   s0;
    logic        s0r;
    logic        s1v;
    preg_tag_t   s1;
    logic        s1r;
  } model_op_t;

  logic                        clk;
  logic                        rst_n;
  logic                        flush_i;
  logic                        disp_valid_i;
  rob_age_t                    disp_age_i;
  op_payload_t                 disp_payload_i;
  logic                        disp_src0_valid_i;
  preg_tag_t                   disp_src0_i;
  logic                        disp_src0_ready_i;
  logic                        disp_src1_valid_i;
  preg_tag_t                   disp_src1_i;
  logic                        disp_src1_ready_i;
  preg_tag_t                   disp_dest_i;
  logic                        disp_ready_o;
  logic [`WB_PORTS-1:0]        wb_valid_i;
  preg_tag_t [`WB_PORTS-1:0]   wb_tag_i;
  logic                        issue_valid_o;
  rob_age_t                    issue_age_o;
  op_payload_t                 issue_payload_o;
  preg_tag_t                   issue_dest_o;
  logic                        fu_ready_i;

  model_op_t   model_q[$];
  model_op_t   new_op;
  int          model_seq = 0;
  int          n_accept  = 0;
  int          n_issued  = 0;
  int          n_flushed = 0;
  int          errors    = 0;
  int          timeouts  = 0;
  int          exp_idx;
  logic        has_room;
  logic        took;
  logic [15:0] lfsr_q;
  rob_age_t    woken_age;
  string       test_name;

  issue_stage UUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ====================================================================
  // Stimulus source and reference model
  // ====================================================================
  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Oldest outstanding operation with every used source ready
  function automatic int expected_issue();
    int best;
    best = -1;
    foreach (model_q[i]) begin
      if ((!model_q[i].s0v || model_q[i].s0r) && (!model_q[i].s1v || model_q[i].s1r) &&
          (best < 0 || model_q[i].seq < model_q[best].seq)) begin
        best = i;
      end
    end
    return best;
  endfunction

  function automatic logic tag_seen(input preg_tag_t tag);
    logic hit;
    hit = 1'b0;
    for (int p = 0; p < `WB_PORTS; p++) begin
      hit = hit | (wb_valid_i[p] && wb_tag_i[p] == tag);
    end
    return hit;
  endfunction

  task automatic check(input string field, input logic [31:0] exp_v,
                       input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      errors++;
      $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, field, exp_v, act_v);
    end
  endtask

  task automatic report_timeout(input string what);
    timeouts++;
    $display("Timeout in test %s while waiting for %s", test_name, what);
  endtask

  // Compare on the falling edge, then apply what the next rising edge does
  always @(negedge clk) begin
    if (rst_n) begin
      exp_idx  = expected_issue();
      has_room = (model_q.size() < CAP);
      check("issue_valid", exp_idx >= 0, issue_valid_o);
      if (exp_idx >= 0) begin
        check("issue_age", model_q[exp_idx].age, issue_age_o);
        check("issue_payload", model_q[exp_idx].payload, issue_payload_o);
        check("issue_dest", model_q[exp_idx].dest, issue_dest_o);
      end
      check("disp_ready", has_room, disp_ready_o);
      if (flush_i) begin
        n_flushed += model_q.size();
        model_q.delete();
      end else begin
        // Handshakes the DUT actually performs
        if (issue_valid_o && fu_ready_i) n_issued++;
        if (disp_valid_i && disp_ready_o) n_accept++;
        foreach (model_q[i]) begin
          if (tag_seen(model_q[i].s0)) model_q[i].s0r = 1'b1;
          if (tag_seen(model_q[i].s1)) model_q[i].s1r = 1'b1;
        end
        if (fu_ready_i && exp_idx >= 0) begin
          model_q.delete(exp_idx);
        end
        if (disp_valid_i && has_room) begin
          new_op = '{model_seq, disp_age_i, disp_payload_i, disp_dest_i,
                     disp_src0_valid_i, disp_src0_i, disp_src0_ready_i | tag_seen(disp_src0_i),
                     disp_src1_valid_i, disp_src1_i, disp_src1_ready_i | tag_seen(disp_src1_i)};
          model_q.push_back(new_op);
          model_seq++;
        end
      end
    end
  end

  // ====================================================================
  // Drivers
  // ====================================================================
  task automatic next_cycle();
    @(negedge clk);
    took = disp_valid_i && disp_ready_o;
    @(posedge clk);
    #2;
    disp_age_i = rob_age_t'(model_seq);
  endtask

  // Source tags come from a small pool so random wakeups hit them
  task automatic set_op(input logic all_ready);
    disp_payload_i    = op_payload_t'(rand_bits(`OP_PAYLOAD_W));
    disp_dest_i       = preg_tag_t'(rand_bits(`PREG_TAG_W));
    disp_src0_valid_i = rand_bits(1);
    disp_src0_i       = preg_tag_t'(rand_bits(3));
    disp_src0_ready_i = all_ready | rand_bits(1);
    disp_src1_valid_i = rand_bits(1);
    disp_src1_i       = preg_tag_t'(rand_bits(3));
    disp_src1_ready_i = all_ready | rand_bits(1);
  endtask

  task automatic offer();
    int t;
    t = 0;
    disp_valid_i = 1'b1;
    do begin
      next_cycle();
      t++;
    end while (!took && t < 50);
    if (!took) report_timeout("dispatch to be accepted");
    disp_valid_i = 1'b0;
  endtask

  task automatic send_op(input logic all_ready);
    set_op(all_ready);
    offer();
  endtask

  // Dispatch until both banks are full, counting accepted operations
  task automatic fill_banks();
    int cnt;
    int t;
    cnt = 0;
    t   = 0;
    set_op(1'b0);
    disp_valid_i = 1'b1;
    while (disp_ready_o && t < 40) begin
      next_cycle();
      if (took) cnt++;
      set_op(1'b0);
      t++;
    end
    disp_valid_i = 1'b0;
    if (disp_ready_o) report_timeout("disp_ready_o to fall");
    check("fill_count", CAP, cnt);
  endtask

  // Sweep every tag over the writeback ports until the model is empty
  task automatic drain();
    int t;
    t            = 0;
    fu_ready_i   = 1'b1;
    disp_valid_i = 1'b0;
    while (model_q.size() != 0 && t < 200) begin
      for (int p = 0; p < `WB_PORTS; p++) begin
        wb_valid_i[p] = 1'b1;
        wb_tag_i[p]   = preg_tag_t'(`WB_PORTS * t + p);
      end
      next_cycle();
      t++;
    end
    wb_valid_i = '0;
    if (model_q.size() != 0) report_timeout("the banks to drain");
    next_cycle();
  endtask

  initial begin
    lfsr_q       = 16'd35567;
    rst_n        = 1'b0;
    flush_i      = 1'b0;
    disp_valid_i = 1'b0;
    disp_age_i   = '0;
    set_op(1'b1);
    wb_valid_i   = '0;
    wb_tag_i     = '0;
    fu_ready_i   = 1'b0;
    test_name    = "reset";
    repeat (10) @(posedge clk);
    #2 rst_n = 1'b1;
    next_cycle();
    check("reset_issue_valid", 1'b0, issue_valid_o);
    check("reset_disp_ready", 1'b1, disp_ready_o);

    // Ready operations in age order, past two ROB wraps
    test_name  = "age_order";
    fu_ready_i = 1'b1;
    repeat (40) send_op(1'b1);
    drain();

    // Two blocked operations ahead of ready ones
    test_name = "wakeup";
    set_op(1'b1);
    disp_src0_valid_i = 1'b1;
    disp_src0_i       = preg_tag_t'(45);
    disp_src0_ready_i = 1'b0;
    woken_age         = disp_age_i;
    offer();
    set_op(1'b1);
    disp_src1_valid_i = 1'b1;
    disp_src1_i       = preg_tag_t'(46);
    disp_src1_ready_i = 1'b0;
    offer();
    repeat (3) send_op(1'b1);
    repeat (3) next_cycle();
    wb_valid_i  = `WB_PORTS'(1);
    wb_tag_i[0] = preg_tag_t'(45);
    next_cycle();
    wb_valid_i = '0;
    check("woken_age", woken_age, issue_age_o);
    drain();

    test_name  = "backpressure";
    fu_ready_i = 1'b0;
    fill_banks();
    repeat (5) next_cycle();
    drain();

    // Keep the outstanding window inside half the age space
    test_name = "random";
    repeat (400) begin
      fu_ready_i = (rand_bits(2) != 0);
      for (int p = 0; p < `WB_PORTS; p++) begin
        wb_valid_i[p] = (rand_bits(2) == 0);
        wb_tag_i[p]   = preg_tag_t'(rand_bits(3));
      end
      set_op(1'b0);
      disp_valid_i = rand_bits(1) &&
                     (model_q.size() == 0 || model_seq - model_q[0].seq < 15);
      next_cycle();
    end
    drain();

    test_name  = "flush";
    fu_ready_i = 1'b0;
    repeat (5) send_op(1'b1);
    flush_i = 1'b1;
    next_cycle();
    flush_i = 1'b0;
    check("flush_issue_valid", 1'b0, issue_valid_o);
    fill_banks();
    drain();

    test_name = "totals";
    check("op_count", n_accept, n_issued + n_flushed);
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+include
source/rs_pkg.sv
source/dispatch_steer.sv
source/rs_bank.sv
source/issue_arbiter.sv
source/issue_stage.sv
tests/tb_issue_stage.sv
